// File: Bender.yml
package:
  name: riscv_core

sources:
  - hw/riscv_pkg.sv
  - hw/rv_decoder.sv
  - hw/rv_regfile.sv
  - hw/rv_execute.sv
  - hw/rv_mem_stage.sv
  - hw/rv_control.sv
  - hw/riscv_core.sv
  - target: simulation
    files:
      - tb/tb_memory.sv
      - tb/tb_riscv_core.sv

// File: hw/riscv_core.sv
module riscv_core (
  input  logic             clk,
  input  logic             reset,
  output logic             mem_valid,
  output logic             mem_instr,
  input  logic             mem_ready,
  output riscv_pkg::word_t mem_addr,
  output riscv_pkg::word_t mem_wdata,
  output riscv_pkg::strb_t mem_wstrb,
  input  riscv_pkg::word_t mem_rdata,
  output logic             trap
);
  import riscv_pkg::*;

  decoded_t     dec;
  logic         legal;
  exec_result_t res;
  word_t        instr;
  word_t        pc;
  logic         fetch_start;
  word_t        fetch_addr;
  logic         data_start;
  load_req_t    load_sel;
  logic         reg_we;
  reg_addr_t    reg_waddr;
  word_t        reg_wdata;
  word_t        rs1_data;
  word_t        rs2_data;
  logic         mem_done;
  word_t        rdata;

  rv_control control_i (
    .clk, .reset, .dec, .legal, .res, .mem_done, .rdata,
    .instr, .pc, .fetch_start, .fetch_addr, .data_start, .load_sel,
    .reg_we, .reg_waddr, .reg_wdata, .trap
  );

  rv_decoder decoder_i (.instr, .dec, .legal);

  rv_regfile regfile_i (
    .clk, .reset, .rs1(dec.rs1), .rs2(dec.rs2),
    .we(reg_we), .rd(reg_waddr), .wdata(reg_wdata), .rs1_data, .rs2_data
  );

  rv_execute execute_i (.dec, .pc, .rs1_data, .rs2_data, .res);

  rv_mem_stage mem_stage_i (
    .clk, .reset, .fetch_start, .fetch_addr, .data_start, .req(res), .load_sel,
    .mem_ready, .mem_rdata, .mem_valid, .mem_instr, .mem_addr, .mem_wdata,
    .mem_wstrb, .mem_done, .rdata
  );

endmodule

// File: hw/riscv_pkg.sv
package riscv_pkg;

  localparam int xlen = 32;
  localparam int nregs = 32;
  localparam logic [xlen-1:0] reset_pc = '0;

  typedef logic [xlen-1:0] word_t;
  typedef logic [$clog2(nregs)-1:0] reg_addr_t;
  typedef logic [xlen/8-1:0] strb_t;

  // major opcodes of the kept RV32I subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_op     = 7'b0110011
  } opcode_e;

  // encoded as {alternate bit, funct3}
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_e;

  // branch funct3 values
  typedef enum logic [2:0] {
    br_eq  = 3'b000,
    br_ne  = 3'b001,
    br_lt  = 3'b100,
    br_ge  = 3'b101,
    br_ltu = 3'b110,
    br_geu = 3'b111
  } branch_e;

  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } mem_size_e;

  typedef enum logic [2:0] {
    cls_lui,
    cls_auipc,
    cls_jump,
    cls_branch,
    cls_load,
    cls_store,
    cls_alu
  } insn_class_e;

  typedef enum logic [2:0] {
    st_fetch,
    st_wait_fetch,
    st_execute,
    st_memory,
    st_writeback,
    st_check_pc,
    st_trap
  } cpu_state_e;

  typedef struct packed {
    insn_class_e cls;
    alu_op_e     alu_op;
    branch_e     branch;
    mem_size_e   size;
    logic        load_unsigned;
    logic        is_jalr;
    logic        use_imm;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       imm;
  } decoded_t;

  typedef struct packed {
    word_t      wb_value;
    logic       writes_rd;
    word_t      next_pc;
    logic       check_pc;
    logic       data_req;
    logic       is_store;
    word_t      addr;
    logic [1:0] byte_offset;
    word_t      store_data;
    strb_t      strb;
    logic       misaligned;
  } exec_result_t;

  typedef struct packed {
    mem_size_e  size;
    logic       is_unsigned;
    logic [1:0] offset;
  } load_req_t;

endpackage

// File: hw/rv_control.sv
module rv_control (
  input  logic                    clk,
  input  logic                    reset,
  input  riscv_pkg::decoded_t     dec,
  input  logic                    legal,
  input  riscv_pkg::exec_result_t res,
  input  logic                    mem_done,
  input  riscv_pkg::word_t        rdata,
  output riscv_pkg::word_t        instr,
  output riscv_pkg::word_t        pc,
  output logic                    fetch_start,
  output riscv_pkg::word_t        fetch_addr,
  output logic                    data_start,
  output riscv_pkg::load_req_t    load_sel,
  output logic                    reg_we,
  output riscv_pkg::reg_addr_t    reg_waddr,
  output riscv_pkg::word_t        reg_wdata,
  output logic                    trap
);
  import riscv_pkg::*;

  cpu_state_e state;
  word_t      next_pc;
  word_t      wb_data;
  logic       exec_ok;

  assign exec_ok = legal && !res.misaligned;

  assign fetch_start = state == st_fetch;
  assign fetch_addr = next_pc;
  assign data_start = state == st_execute && exec_ok && res.data_req;
  assign load_sel = '{size: dec.size, is_unsigned: dec.load_unsigned, offset: res.byte_offset};

  // instr is held through writeback, so dec and res stay valid here
  assign reg_we = state == st_writeback && res.writes_rd;
  assign reg_waddr = dec.rd;
  assign reg_wdata = wb_data;
  assign trap = state == st_trap;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      pc <= reset_pc;
      next_pc <= reset_pc;
    end else begin
      case (state)
        st_fetch: begin
          state <= st_wait_fetch;
        end
        st_wait_fetch: begin
          if (mem_done) begin
            pc <= next_pc;
            state <= st_execute;
          end
        end
        st_execute: begin
          if (!exec_ok) begin
            state <= st_trap;
          end else begin
            next_pc <= res.next_pc;
            state <= res.data_req ? st_memory : st_writeback;
          end
        end
        st_memory: begin
          if (mem_done) begin
            state <= res.is_store ? st_fetch : st_writeback;
          end
        end
        st_writeback: begin
          state <= res.check_pc ? st_check_pc : st_fetch;
        end
        // jump and branch targets must be word aligned
        st_check_pc: begin
          state <= |next_pc[1:0] ? st_trap : st_fetch;
        end
        st_trap: begin
          state <= st_trap;
        end
        default: begin
          state <= st_trap;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_wait_fetch && mem_done) begin
      instr <= rdata;
    end
    if (state == st_execute) begin
      wb_data <= res.wb_value;
    end else if (state == st_memory && mem_done) begin
      wb_data <= rdata;
    end
  end

endmodule

// File: hw/rv_decoder.sv
module rv_decoder (
  input  riscv_pkg::word_t    instr,
  output riscv_pkg::decoded_t dec,
  output logic                legal
);
  import riscv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec = '0;
    dec.rd = instr[11:7];
    dec.rs1 = instr[19:15];
    dec.rs2 = instr[24:20];
    legal = 1'b0;
    case (opcode)
      op_lui: begin
        dec.cls = cls_lui;
        dec.imm = imm_u;
        legal = 1'b1;
      end
      op_auipc: begin
        dec.cls = cls_auipc;
        dec.imm = imm_u;
        legal = 1'b1;
      end
      op_jal: begin
        dec.cls = cls_jump;
        dec.imm = imm_j;
        legal = 1'b1;
      end
      op_jalr: begin
        dec.cls = cls_jump;
        dec.is_jalr = 1'b1;
        dec.imm = imm_i;
        legal = funct3 == 3'b000;
      end
      op_branch: begin
        dec.cls = cls_branch;
        dec.branch = branch_e'(funct3);
        dec.imm = imm_b;
        dec.rd = '0;
        legal = funct3[2:1] != 2'b01;
      end
      op_load: begin
        dec.cls = cls_load;
        dec.size = mem_size_e'(funct3[1:0]);
        dec.load_unsigned = funct3[2];
        dec.imm = imm_i;
        legal = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
      end
      op_store: begin
        dec.cls = cls_store;
        dec.size = mem_size_e'(funct3[1:0]);
        dec.imm = imm_s;
        dec.rd = '0;
        legal = funct3 inside {3'b000, 3'b001, 3'b010};
      end
      op_imm: begin
        dec.cls = cls_alu;
        dec.use_imm = 1'b1;
        dec.imm = imm_i;
        // only the right shift has an alternate form here, addi keeps bit 30 as immediate
        dec.alu_op = alu_op_e'({funct3 == 3'b101 && funct7[5], funct3});
        if (funct3 == 3'b001) begin
          legal = funct7 == 7'b0000000;
        end else if (funct3 == 3'b101) begin
          legal = funct7 inside {7'b0000000, 7'b0100000};
        end else begin
          legal = 1'b1;
        end
      end
      op_op: begin
        dec.cls = cls_alu;
        dec.alu_op = alu_op_e'({funct7[5], funct3});
        legal = funct7 == 7'b0000000 ||
                (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101});
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

endmodule

// File: hw/rv_execute.sv
module rv_execute (
  input  riscv_pkg::decoded_t     dec,
  input  riscv_pkg::word_t        pc,
  input  riscv_pkg::word_t        rs1_data,
  input  riscv_pkg::word_t        rs2_data,
  output riscv_pkg::exec_result_t res
);
  import riscv_pkg::*;

  word_t      op_b;
  logic [4:0] shamt;
  word_t      alu_value;
  word_t      link;
  word_t      pc_target;
  word_t      jump_target;
  word_t      ls_addr;
  logic       taken;
  logic       ls_misaligned;
  word_t      st_data;
  strb_t      st_strb;

  assign op_b = dec.use_imm ? dec.imm : rs2_data;
  // for shift immediates the low five bits of imm are the shamt field
  assign shamt = op_b[4:0];
  assign link = pc + 32'd4;
  assign pc_target = pc + dec.imm;
  assign jump_target = dec.is_jalr ? ((rs1_data + dec.imm) & ~32'd1) : pc_target;
  assign ls_addr = rs1_data + dec.imm;

  always_comb begin
    case (dec.alu_op)
      alu_add:  alu_value = rs1_data + op_b;
      alu_sub:  alu_value = rs1_data - op_b;
      alu_sll:  alu_value = rs1_data << shamt;
      alu_slt:  alu_value = {31'b0, $signed(rs1_data) < $signed(op_b)};
      alu_sltu: alu_value = {31'b0, rs1_data < op_b};
      alu_xor:  alu_value = rs1_data ^ op_b;
      alu_srl:  alu_value = rs1_data >> shamt;
      alu_sra:  alu_value = $signed(rs1_data) >>> shamt;
      alu_or:   alu_value = rs1_data | op_b;
      alu_and:  alu_value = rs1_data & op_b;
      default:  alu_value = '0;
    endcase

    case (dec.branch)
      br_eq:   taken = rs1_data == rs2_data;
      br_ne:   taken = rs1_data != rs2_data;
      br_lt:   taken = $signed(rs1_data) < $signed(rs2_data);
      br_ge:   taken = $signed(rs1_data) >= $signed(rs2_data);
      br_ltu:  taken = rs1_data < rs2_data;
      br_geu:  taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase

    // sub-word stores replicate the value over all lanes
    case (dec.size)
      size_byte: begin
        st_data = {4{rs2_data[7:0]}};
        st_strb = strb_t'(4'b0001) << ls_addr[1:0];
        ls_misaligned = 1'b0;
      end
      size_half: begin
        st_data = {2{rs2_data[15:0]}};
        st_strb = ls_addr[1] ? 4'b1100 : 4'b0011;
        ls_misaligned = ls_addr[0];
      end
      default: begin
        st_data = rs2_data;
        st_strb = 4'b1111;
        ls_misaligned = |ls_addr[1:0];
      end
    endcase
  end

  always_comb begin
    res = '0;
    res.next_pc = link;
    res.addr = {ls_addr[31:2], 2'b00};
    res.byte_offset = ls_addr[1:0];
    res.store_data = st_data;
    res.strb = st_strb;
    case (dec.cls)
      cls_lui: begin
        res.wb_value = dec.imm;
        res.writes_rd = 1'b1;
      end
      cls_auipc: begin
        res.wb_value = pc_target;
        res.writes_rd = 1'b1;
      end
      cls_jump: begin
        res.wb_value = link;
        res.writes_rd = 1'b1;
        res.next_pc = jump_target;
        res.check_pc = 1'b1;
      end
      cls_branch: begin
        res.next_pc = taken ? pc_target : link;
        res.check_pc = 1'b1;
      end
      cls_load: begin
        res.writes_rd = 1'b1;
        res.data_req = 1'b1;
        res.misaligned = ls_misaligned;
      end
      cls_store: begin
        res.data_req = 1'b1;
        res.is_store = 1'b1;
        res.misaligned = ls_misaligned;
      end
      default: begin
        res.wb_value = alu_value;
        res.writes_rd = 1'b1;
      end
    endcase
  end

endmodule

// File: hw/rv_mem_stage.sv
module rv_mem_stage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    fetch_start,
  input  riscv_pkg::word_t        fetch_addr,
  input  logic                    data_start,
  input  riscv_pkg::exec_result_t req,
  input  riscv_pkg::load_req_t    load_sel,
  input  logic                    mem_ready,
  input  riscv_pkg::word_t        mem_rdata,
  output logic                    mem_valid,
  output logic                    mem_instr,
  output riscv_pkg::word_t        mem_addr,
  output riscv_pkg::word_t        mem_wdata,
  output riscv_pkg::strb_t        mem_wstrb,
  output logic                    mem_done,
  output riscv_pkg::word_t        rdata
);
  import riscv_pkg::*;

  load_req_t  lsel_q;
  logic       xfer;
  logic [7:0] lane_byte;
  logic [15:0] lane_half;
  word_t      read_value;

  assign xfer = mem_valid && mem_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
      mem_done <= 1'b0;
    end else begin
      mem_done <= xfer;
      if (fetch_start || data_start) begin
        mem_valid <= 1'b1;
      end else if (xfer) begin
        mem_valid <= 1'b0;
      end
    end
  end

  // request held here until the transfer edge
  always_ff @(posedge clk) begin
    if (fetch_start) begin
      mem_instr <= 1'b1;
      mem_addr <= fetch_addr;
      mem_wstrb <= '0;
    end else if (data_start) begin
      mem_instr <= 1'b0;
      mem_addr <= req.addr;
      mem_wdata <= req.store_data;
      mem_wstrb <= req.is_store ? req.strb : '0;
      lsel_q <= load_sel;
    end
    if (xfer) begin
      rdata <= read_value;
    end
  end

  assign lane_byte = mem_rdata[{lsel_q.offset, 3'b000} +: 8];
  assign lane_half = lsel_q.offset[1] ? mem_rdata[31:16] : mem_rdata[15:0];

  always_comb begin
    if (mem_instr) begin
      read_value = mem_rdata;
    end else begin
      case (lsel_q.size)
        size_byte: read_value = {{24{~lsel_q.is_unsigned & lane_byte[7]}}, lane_byte};
        size_half: read_value = {{16{~lsel_q.is_unsigned & lane_half[15]}}, lane_half};
        default:   read_value = mem_rdata;
      endcase
    end
  end

endmodule

// File: hw/rv_regfile.sv
module rv_regfile (
  input  logic                 clk,
  input  logic                 reset,
  input  riscv_pkg::reg_addr_t rs1,
  input  riscv_pkg::reg_addr_t rs2,
  input  logic                 we,
  input  riscv_pkg::reg_addr_t rd,
  input  riscv_pkg::word_t     wdata,
  output riscv_pkg::word_t     rs1_data,
  output riscv_pkg::word_t     rs2_data
);
  import riscv_pkg::*;

  word_t regs [nregs];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < nregs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 always reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: tb/tb_memory.sv
module tb_memory (
  input  logic             clk,
  input  logic             reset,
  input  logic             mem_valid,
  input  riscv_pkg::word_t mem_addr,
  input  riscv_pkg::word_t mem_wdata,
  input  riscv_pkg::strb_t mem_wstrb,
  output logic             mem_ready,
  output riscv_pkg::word_t mem_rdata
);
  timeunit 1ns;
  timeprecision 100ps;
  import riscv_pkg::*;

  localparam int depth = 512;

  word_t       mem [depth];
  logic [31:0] lcg_state;
  int          wait_left;
  logic        counting;
  logic [8:0]  index;

  assign index = mem_addr[10:2];

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    lcg_state = 32'h1466_4e08;
    counting = 1'b0;
    wait_left = 0;
    // every word differs, so a stray read is easy to spot
    for (int i = 0; i < depth; i++) begin
      mem[i] = 32'hdead_0000 ^ 32'(i);
    end
  end

  // ready and read data change on the falling edge only
  always @(negedge clk) begin
    if (reset) begin
      mem_ready <= 1'b0;
      counting = 1'b0;
    end else if (mem_ready) begin
      // transfer took place on the last rising edge
      mem_ready <= 1'b0;
    end else if (mem_valid) begin
      if (!counting) begin
        lcg_state = lcg_next(lcg_state);
        wait_left = int'(lcg_state[31:30]);
        counting = 1'b1;
      end
      if (wait_left == 0) begin
        mem_ready <= 1'b1;
        mem_rdata <= mem[index];
        counting = 1'b0;
      end else begin
        wait_left--;
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && mem_valid && mem_ready) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wstrb[b]) begin
          mem[index][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: tb/tb_riscv_core.sv
module tb_riscv_core;
  timeunit 1ns;
  timeprecision 100ps;
  import riscv_pkg::*;

  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_jalr = 7'b1100111;
  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_imm = 7'b0010011;
  localparam logic [11:0] poison = 12'h7ad;

  localparam word_t sig_base = 32'h400;
  localparam word_t data_base = 32'h600;
  localparam word_t op_a = 32'h8765_4321;
  localparam word_t op_b = 32'd19;
  localparam word_t op_c = 32'hffff_ff9c;
  localparam word_t store_val = 32'h1234_56a5;
  localparam word_t load_data = 32'h7ef1_8082;

  logic  clk = 1'b0;
  logic  reset = 1'b1;
  logic  mem_valid;
  logic  mem_instr;
  logic  mem_ready;
  word_t mem_addr;
  word_t mem_wdata;
  strb_t mem_wstrb;
  word_t mem_rdata;
  logic  trap;

  word_t prog [$];
  word_t exp_addr [$];
  word_t exp_data [$];
  strb_t exp_strb [$];
  string exp_name [$];
  int    sig_off = 0;
  int    store_idx = 0;
  int    prog_len = 0;
  int    store_errors = 0;
  int    bus_errors = 0;
  int    end_errors = 0;

  always #5 clk = ~clk;

  riscv_core dut_i (
    .clk, .reset, .mem_valid, .mem_instr, .mem_ready, .mem_addr,
    .mem_wdata, .mem_wstrb, .mem_rdata, .trap
  );

  tb_memory mem_i (
    .clk, .reset, .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb, .mem_ready, .mem_rdata
  );

  function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, rs1,
                                   logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                   logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // sign or zero extension of a lane of the data word, per funct3
  function automatic word_t load_value(input logic [2:0] f3, input int off);
    logic [7:0]  b;
    logic [15:0] h;
    b = load_data[8*off +: 8];
    h = load_data[8*off +: 16];
    case (f3)
      3'b000:  return {{24{b[7]}}, b};
      3'b100:  return {24'b0, b};
      3'b001:  return {{16{h[15]}}, h};
      3'b101:  return {16'b0, h};
      default: return load_data;
    endcase
  endfunction

  function automatic word_t next_pc_value();
    return word_t'(prog.size() * 4);
  endfunction

  task automatic emit(input word_t insn);
    prog.push_back(insn);
  endtask

  task automatic expect_store(input string name, input word_t addr, input word_t data,
                              input strb_t strb);
    exp_name.push_back(name);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_strb.push_back(strb);
  endtask

  // x10 goes to the next signature word
  task automatic store_result(input string name, input word_t value);
    emit(s_type(12'(sig_off), 10, 31, 3'b010));
    expect_store(name, sig_base + word_t'(sig_off), value, 4'b1111);
    sig_off += 4;
  endtask

  task automatic check_op(input string name, input word_t insn, input word_t value);
    emit(insn);
    store_result(name, value);
  endtask

  task automatic branch_case(input string name, input logic [2:0] f3,
                             input logic [4:0] rs1, rs2, input logic taken);
    emit(b_type(13'd12, rs2, rs1, f3));
    emit(i_type(12'd1, 0, 3'b000, 10, opc_imm));
    emit(j_type(21'd8, 0));
    emit(i_type(12'd2, 0, 3'b000, 10, opc_imm));
    store_result(name, taken ? 32'd2 : 32'd1);
  endtask

  task automatic load_case(input string name, input logic [2:0] f3, input int off);
    emit(i_type(12'(off), 15, f3, 10, opc_load));
    store_result($sformatf("%s_%0d", name, off), load_value(f3, off));
  endtask

  task automatic build_program();
    word_t p;
    // x1 = op_a, x2 = op_b, x3 = op_c, x31 signature, x15 data, x14 store value
    emit(u_type(20'h87654, 1, opc_lui));
    emit(i_type(12'h321, 1, 3'b000, 1, opc_imm));
    emit(i_type(12'd19, 0, 3'b000, 2, opc_imm));
    emit(i_type(12'hf9c, 0, 3'b000, 3, opc_imm));
    emit(i_type(12'h400, 0, 3'b000, 31, opc_imm));
    emit(i_type(12'h600, 0, 3'b000, 15, opc_imm));
    emit(u_type(20'h12345, 14, opc_lui));
    emit(i_type(12'h6a5, 14, 3'b000, 14, opc_imm));

    check_op("add", r_type(7'h00, 3, 1, 3'b000, 10), op_a + op_c);
    check_op("sub", r_type(7'h20, 2, 1, 3'b000, 10), op_a - op_b);
    check_op("sll", r_type(7'h00, 2, 1, 3'b001, 10), op_a << op_b[4:0]);
    check_op("slt", r_type(7'h00, 3, 1, 3'b010, 10), {31'b0, $signed(op_a) < $signed(op_c)});
    check_op("sltu", r_type(7'h00, 3, 1, 3'b011, 10), {31'b0, op_a < op_c});
    check_op("sltu_rev", r_type(7'h00, 1, 3, 3'b011, 10), {31'b0, op_c < op_a});
    check_op("xor", r_type(7'h00, 3, 1, 3'b100, 10), op_a ^ op_c);
    check_op("srl", r_type(7'h00, 2, 1, 3'b101, 10), op_a >> op_b[4:0]);
    check_op("sra", r_type(7'h20, 2, 1, 3'b101, 10), word_t'($signed(op_a) >>> op_b[4:0]));
    check_op("or", r_type(7'h00, 3, 1, 3'b110, 10), op_a | op_c);
    check_op("and", r_type(7'h00, 3, 1, 3'b111, 10), op_a & op_c);

    check_op("addi", i_type(12'hffb, 1, 3'b000, 10, opc_imm), op_a - 32'd5);
    check_op("slti", i_type(12'hf9d, 3, 3'b010, 10, opc_imm),
             {31'b0, $signed(op_c) < $signed(-32'sd99)});
    check_op("sltiu", i_type(12'hfff, 1, 3'b011, 10, opc_imm), {31'b0, op_a < 32'hffff_ffff});
    check_op("xori", i_type(12'h555, 1, 3'b100, 10, opc_imm), op_a ^ 32'h555);
    check_op("ori", i_type(12'h0f0, 1, 3'b110, 10, opc_imm), op_a | 32'h0f0);
    check_op("andi", i_type(12'h7f0, 1, 3'b111, 10, opc_imm), op_a & 32'h7f0);
    check_op("slli", i_type(12'h007, 1, 3'b001, 10, opc_imm), op_a << 7);
    check_op("srli", i_type(12'h009, 1, 3'b101, 10, opc_imm), op_a >> 9);
    check_op("srai", i_type(12'h409, 1, 3'b101, 10, opc_imm), word_t'($signed(op_a) >>> 9));
    check_op("lui", u_type(20'habcde, 10, opc_lui), 32'habcd_e000);
    p = next_pc_value();
    check_op("auipc", u_type(20'h12345, 10, opc_auipc), p + 32'h1234_5000);

    // op_a is negative, op_c = -100, op_b = 19
    branch_case("beq_t", 3'b000, 2, 2, 1'b1);
    branch_case("beq_n", 3'b000, 2, 3, 1'b0);
    branch_case("bne_t", 3'b001, 2, 3, 1'b1);
    branch_case("bne_n", 3'b001, 2, 2, 1'b0);
    branch_case("blt_t", 3'b100, 1, 3, 1'b1);
    branch_case("blt_n", 3'b100, 3, 1, 1'b0);
    branch_case("bge_t", 3'b101, 3, 1, 1'b1);
    branch_case("bge_n", 3'b101, 1, 3, 1'b0);
    branch_case("bltu_t", 3'b110, 2, 1, 1'b1);
    branch_case("bltu_n", 3'b110, 1, 2, 1'b0);
    branch_case("bgeu_t", 3'b111, 3, 1, 1'b1);
    branch_case("bgeu_n", 3'b111, 2, 3, 1'b0);

    // the skipped pair stores poison only if the jump is not taken
    p = next_pc_value();
    emit(j_type(21'd12, 10));
    emit(i_type(poison, 0, 3'b000, 12, opc_imm));
    emit(s_type(12'(sig_off), 12, 31, 3'b010));
    store_result("jal_link", p + 32'd4);

    // odd offset, target low bit is cleared
    p = next_pc_value();
    emit(u_type(20'h0, 13, opc_auipc));
    emit(i_type(12'd17, 13, 3'b000, 10, opc_jalr));
    emit(i_type(poison, 0, 3'b000, 12, opc_imm));
    emit(s_type(12'(sig_off), 12, 31, 3'b010));
    store_result("jalr_link", p + 32'd8);

    for (int k = 0; k < 4; k++) begin
      emit(s_type(12'(sig_off + k), 14, 31, 3'b000));
      expect_store($sformatf("sb_%0d", k), sig_base + word_t'(sig_off),
                   {4{store_val[7:0]}}, strb_t'(4'b0001 << k));
    end
    sig_off += 4;
    for (int k = 0; k < 4; k += 2) begin
      emit(s_type(12'(sig_off + k), 14, 31, 3'b001));
      expect_store($sformatf("sh_%0d", k), sig_base + word_t'(sig_off),
                   {2{store_val[15:0]}}, (k == 2) ? 4'b1100 : 4'b0011);
    end
    sig_off += 4;

    for (int k = 0; k < 4; k++) begin
      load_case("lb", 3'b000, k);
      load_case("lbu", 3'b100, k);
    end
    for (int k = 0; k < 4; k += 2) begin
      load_case("lh", 3'b001, k);
      load_case("lhu", 3'b101, k);
    end
    load_case("lw", 3'b010, 0);

    // misaligned word load ends the program with a trap
    emit(i_type(12'd2, 15, 3'b010, 10, opc_load));
  endtask

  always @(posedge clk) begin
    if (!reset && mem_valid && mem_ready && mem_wstrb != '0) begin
      if (store_idx >= exp_addr.size()) begin
        store_errors++;
        $display("unexpected store to %h after the last expected store", mem_addr);
      end else begin
        store_ok: assert (mem_addr == exp_addr[store_idx] && mem_wdata == exp_data[store_idx]
                          && mem_wstrb == exp_strb[store_idx])
          else begin
            store_errors++;
            $display("Fail %s: expected addr %h data %h strb %b, actual addr %h data %h strb %b",
                     exp_name[store_idx], exp_addr[store_idx], exp_data[store_idx],
                     exp_strb[store_idx], mem_addr, mem_wdata, mem_wstrb);
          end
      end
      store_idx++;
    end
  end

  reset_state: assert property (@(posedge clk)
      $fell(reset) |-> (!mem_valid && !trap) ##1 (mem_valid && mem_instr && mem_addr == reset_pc))
    else begin
      bus_errors++;
      $display("first fetch after reset is not at the reset address");
    end

  bus_hold: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=>
        mem_valid && $stable(mem_addr) && $stable(mem_instr) && $stable(mem_wstrb))
    else begin
      bus_errors++;
      $display("request changed while mem_ready was low at %0t", $time);
    end

  wdata_hold: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready && mem_wstrb != '0 |=> $stable(mem_wdata))
    else begin
      bus_errors++;
      $display("store data changed while mem_ready was low at %0t", $time);
    end

  fetch_form: assert property (@(posedge clk) disable iff (reset)
      mem_valid && mem_instr |-> mem_wstrb == '0 && mem_addr < word_t'(prog_len * 4))
    else begin
      bus_errors++;
      $display("fetch with a strobe or outside the program at %0t", $time);
    end

  data_form: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_instr |-> mem_addr >= sig_base)
    else begin
      bus_errors++;
      $display("data request into the program area, or a fetch without mem_instr");
    end

  valid_drop: assert property (@(posedge clk) disable iff (reset)
      mem_valid && mem_ready |=> !mem_valid)
    else begin
      bus_errors++;
      $display("mem_valid stayed high after a transfer at %0t", $time);
    end

  trap_hold: assert property (@(posedge clk) disable iff (reset)
      trap |=> trap && !mem_valid)
    else begin
      bus_errors++;
      $display("trap dropped or a request followed the trap at %0t", $time);
    end

  initial begin
    build_program();
    prog_len = prog.size();
    @(negedge clk);
    foreach (prog[i]) begin
      mem_i.mem[i] = prog[i];
    end
    mem_i.mem[data_base >> 2] = load_data;
    repeat (9) @(negedge clk);
    reset = 1'b0;
    wait (trap);
    repeat (20) @(negedge clk);
    if (store_idx != exp_addr.size()) begin
      end_errors++;
      $display("trap came after %0d of %0d expected stores", store_idx, exp_addr.size());
    end
    $display("errors: %0d store, %0d bus, %0d end", store_errors, bus_errors, end_errors);
    if (store_errors + bus_errors + end_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // 40 cycles per instruction, plus reset and the check after the trap
  initial begin
    wait (prog_len > 0);
    repeat (prog_len * 40 + 30) @(posedge clk);
    $display("watchdog expired, no trap after %0d cycles", prog_len * 40 + 30);
    $display("Test failed");
    $finish;
  end

endmodule

// File: vlog.f
hw/riscv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_mem_stage.sv
hw/rv_control.sv
hw/riscv_core.sv
tb/tb_memory.sv
tb/tb_riscv_core.sv
